// ==== hw/tim_defs.svh ====
`ifndef TIM_DEFS_SVH
`define TIM_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~ memory geometry
`define TIM_BANKS 4 // word-interleaved banks
`define TIM_ROWS 64 // words per bank

// fixed at 64 to match the 8-bit byte strobe
`define TIM_DATA_BITS 64

`endif

// ==== hw/tim_pkg.sv ====
`include "tim_defs.svh"

package tim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~ field widths
  localparam int bank_bits = $clog2(`TIM_BANKS);
  localparam int row_bits = $clog2(`TIM_ROWS);
  localparam int addr_bits = row_bits + bank_bits + 3; // bytes covered by the memory
  localparam int upper_bits = 32 - addr_bits;

  // ~~~~~~~~~~~~~~~~~~~~ byte address views
  typedef struct packed {
    logic [upper_bits-1:0] upper; // must be zero
    logic [row_bits-1:0] row;
    logic [bank_bits-1:0] bank; // low word bits pick the bank
    logic [2:0] offset; // byte in word, unused
  } tim_addr_fields_t;

  typedef union packed {
    logic [31:0] word;
    tim_addr_fields_t fields;
  } tim_addr_u;

endpackage

// ==== hw/tim_decode.sv ====
`timescale 1ns/1ps
`include "tim_defs.svh"

module tim_decode (
  input logic clock,
  input logic reset,
  input logic port0_valid,
  input logic [31:0] port0_addr,
  input logic [7:0] port0_wstrb,
  input logic [`TIM_DATA_BITS-1:0] port0_wdata,
  input logic port1_valid,
  input logic [31:0] port1_addr,
  input logic [7:0] port1_wstrb,
  input logic [`TIM_DATA_BITS-1:0] port1_wdata,
  output logic [`TIM_BANKS-1:0] bank_en0,
  output logic [`TIM_BANKS-1:0] bank_en1,
  output logic [tim_pkg::row_bits-1:0] row0,
  output logic [tim_pkg::row_bits-1:0] row1,
  output logic [7:0] strb0,
  output logic [7:0] strb1,
  output logic [`TIM_DATA_BITS-1:0] wdata0,
  output logic [`TIM_DATA_BITS-1:0] wdata1,
  output logic rsp_valid0,
  output logic rsp_valid1,
  output logic rsp_error0,
  output logic rsp_error1,
  output logic [tim_pkg::bank_bits-1:0] rsp_bank0,
  output logic [tim_pkg::bank_bits-1:0] rsp_bank1
);
  import tim_pkg::*;

  tim_addr_u addr0;
  tim_addr_u addr1;

  // nothing above the last row may be set
  function automatic logic in_range(input tim_addr_u addr);
    return (addr.word >> addr_bits) == 32'd0;
  endfunction

  function automatic logic [`TIM_BANKS-1:0] bank_select(input logic valid,
                                                      input tim_addr_u addr);
    logic [`TIM_BANKS-1:0] en;
    en = '0;
    if (valid && in_range(addr)) begin
      en[addr.fields.bank] = 1'b1; // one-hot and empty when out of range
    end
    return en;
  endfunction

  assign addr0.word = port0_addr;
  assign addr1.word = port1_addr;

  // ~~~~~~~~~~~~~~~~~~~~ bank controls
  assign bank_en0 = bank_select(port0_valid, addr0);
  assign bank_en1 = bank_select(port1_valid, addr1);

  assign row0 = addr0.fields.row; // broadcast to all banks
  assign row1 = addr1.fields.row;
  assign strb0 = port0_wstrb;
  assign strb1 = port1_wstrb;
  assign wdata0 = port0_wdata;
  assign wdata1 = port1_wdata;

  // ~~~~~~~~~~~~~~~~~~~~ response stage
  always_ff @(posedge clock) begin
    if (!reset) begin
      rsp_valid0 <= 1'b0;
      rsp_valid1 <= 1'b0;
      rsp_error0 <= 1'b0;
      rsp_error1 <= 1'b0;
      rsp_bank0 <= '0;
      rsp_bank1 <= '0;
    end else begin
      rsp_valid0 <= port0_valid;
      rsp_valid1 <= port1_valid;
      rsp_error0 <= port0_valid && !in_range(addr0);
      rsp_error1 <= port1_valid && !in_range(addr1);
      rsp_bank0 <= addr0.fields.bank; // picks the read word next cycle
      rsp_bank1 <= addr1.fields.bank;
    end
  end

endmodule

// ==== hw/tim_bank.sv ====
`timescale 1ns/1ps
`include "tim_defs.svh"

module tim_bank (
  input logic clock,
  input logic en0,
  input logic en1,
  input logic [tim_pkg::row_bits-1:0] row0,
  input logic [tim_pkg::row_bits-1:0] row1,
  input logic [7:0] strb0,
  input logic [7:0] strb1,
  input logic [`TIM_DATA_BITS-1:0] wdata0,
  input logic [`TIM_DATA_BITS-1:0] wdata1,
  output logic [`TIM_DATA_BITS-1:0] rdata0,
  output logic [`TIM_DATA_BITS-1:0] rdata1
);

  // eight byte lanes per word
  logic [7:0][7:0] mem [`TIM_ROWS];

  // both ports share one process so that the byte writes are ordered
  // and port 1 comes last to take a byte that both ports write
  always_ff @(posedge clock) begin
    // ~~~~~~~~~~~~~~~~~~~~ port 0
    if (en0) begin
      rdata0 <= mem[row0]; // old word as the write lands
      for (int b = 0; b < 8; b++) begin
        if (strb0[b]) begin
          mem[row0][b] <= wdata0[b*8 +: 8];
        end
      end
    end

    // ~~~~~~~~~~~~~~~~~~~~ port 1
    if (en1) begin
      rdata1 <= mem[row1];
      for (int b = 0; b < 8; b++) begin
        if (strb1[b]) begin
          mem[row1][b] <= wdata1[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== hw/tim_response.sv ====
`timescale 1ns/1ps
`include "tim_defs.svh"

module tim_response (
  input logic rsp_valid0,
  input logic rsp_valid1,
  input logic rsp_error0,
  input logic rsp_error1,
  input logic [tim_pkg::bank_bits-1:0] rsp_bank0,
  input logic [tim_pkg::bank_bits-1:0] rsp_bank1,
  input logic [`TIM_BANKS-1:0][`TIM_DATA_BITS-1:0] bank_rdata0,
  input logic [`TIM_BANKS-1:0][`TIM_DATA_BITS-1:0] bank_rdata1,
  output logic port0_ready,
  output logic [`TIM_DATA_BITS-1:0] port0_rdata,
  output logic port0_error,
  output logic port1_ready,
  output logic [`TIM_DATA_BITS-1:0] port1_rdata,
  output logic port1_error
);

  // ~~~~~~~~~~~~~~~~~~~~ port 0
  assign port0_ready = rsp_valid0; // one cycle after the request
  assign port0_error = rsp_valid0 && rsp_error0;
  assign port0_rdata = rsp_error0 ? '0 : bank_rdata0[rsp_bank0]; // no bank was read

  // ~~~~~~~~~~~~~~~~~~~~ port 1
  assign port1_ready = rsp_valid1;
  assign port1_error = rsp_valid1 && rsp_error1;
  assign port1_rdata = rsp_error1 ? '0 : bank_rdata1[rsp_bank1];

endmodule

// ==== hw/tim.sv ====
`timescale 1ns/1ps
`include "tim_defs.svh"

module tim (
  input logic clock,
  input logic reset,
  input logic port0_valid,
  input logic [31:0] port0_addr,
  input logic [7:0] port0_wstrb,
  input logic [`TIM_DATA_BITS-1:0] port0_wdata,
  output logic port0_ready,
  output logic [`TIM_DATA_BITS-1:0] port0_rdata,
  output logic port0_error,
  input logic port1_valid,
  input logic [31:0] port1_addr,
  input logic [7:0] port1_wstrb,
  input logic [`TIM_DATA_BITS-1:0] port1_wdata,
  output logic port1_ready,
  output logic [`TIM_DATA_BITS-1:0] port1_rdata,
  output logic port1_error
);
  import tim_pkg::*;

  logic [`TIM_BANKS-1:0] bank_en0;
  logic [`TIM_BANKS-1:0] bank_en1;
  logic [row_bits-1:0] row0;
  logic [row_bits-1:0] row1;
  logic [7:0] strb0;
  logic [7:0] strb1;
  logic [`TIM_DATA_BITS-1:0] wdata0;
  logic [`TIM_DATA_BITS-1:0] wdata1;
  logic rsp_valid0;
  logic rsp_valid1;
  logic rsp_error0;
  logic rsp_error1;
  logic [bank_bits-1:0] rsp_bank0;
  logic [bank_bits-1:0] rsp_bank1;
  logic [`TIM_BANKS-1:0][`TIM_DATA_BITS-1:0] bank_rdata0;
  logic [`TIM_BANKS-1:0][`TIM_DATA_BITS-1:0] bank_rdata1;

  // ~~~~~~~~~~~~~~~~~~~~ input side
  tim_decode u_decode (
    .clock(clock),
    .reset(reset),
    .port0_valid(port0_valid),
    .port0_addr(port0_addr),
    .port0_wstrb(port0_wstrb),
    .port0_wdata(port0_wdata),
    .port1_valid(port1_valid),
    .port1_addr(port1_addr),
    .port1_wstrb(port1_wstrb),
    .port1_wdata(port1_wdata),
    .bank_en0(bank_en0),
    .bank_en1(bank_en1),
    .row0(row0),
    .row1(row1),
    .strb0(strb0),
    .strb1(strb1),
    .wdata0(wdata0),
    .wdata1(wdata1),
    .rsp_valid0(rsp_valid0),
    .rsp_valid1(rsp_valid1),
    .rsp_error0(rsp_error0),
    .rsp_error1(rsp_error1),
    .rsp_bank0(rsp_bank0),
    .rsp_bank1(rsp_bank1)
  );

  // ~~~~~~~~~~~~~~~~~~~~ bank array
  for (genvar i = 0; i < `TIM_BANKS; i++) begin : g_bank
    tim_bank u_bank (
      .clock(clock),
      .en0(bank_en0[i]),
      .en1(bank_en1[i]),
      .row0(row0),
      .row1(row1),
      .strb0(strb0),
      .strb1(strb1),
      .wdata0(wdata0),
      .wdata1(wdata1),
      .rdata0(bank_rdata0[i]),
      .rdata1(bank_rdata1[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~ output side
  tim_response u_response (
    .rsp_valid0(rsp_valid0),
    .rsp_valid1(rsp_valid1),
    .rsp_error0(rsp_error0),
    .rsp_error1(rsp_error1),
    .rsp_bank0(rsp_bank0),
    .rsp_bank1(rsp_bank1),
    .bank_rdata0(bank_rdata0),
    .bank_rdata1(bank_rdata1),
    .port0_ready(port0_ready),
    .port0_rdata(port0_rdata),
    .port0_error(port0_error),
    .port1_ready(port1_ready),
    .port1_rdata(port1_rdata),
    .port1_error(port1_error)
  );

endmodule

// ==== verification/tim_tb_model.svh ====
`ifndef TIM_TB_MODEL_SVH
`define TIM_TB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~ memory model
localparam int word_count = `TIM_BANKS * `TIM_ROWS;
localparam int mem_bytes = word_count * 8; // upper address bits start here

logic [7:0] model_mem [mem_bytes];
logic [15:0] lfsr_state = 16'd22165;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [63:0] random_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[62:0], lfsr_state[0]}; // one step per bit
  end
  return v;
endfunction

function automatic logic addr_in_range(input logic [31:0] addr);
  return addr < mem_bytes;
endfunction

function automatic logic [63:0] read_model_word(input logic [31:0] addr);
  logic [63:0] w;
  int base;
  base = addr & 32'hffff_fff8; // byte offset ignored
  for (int b = 0; b < 8; b++) begin
    w[b*8 +: 8] = model_mem[base + b];
  end
  return w;
endfunction

function automatic void write_model_word(input logic [31:0] addr, input logic [7:0] strb,
                                         input logic [63:0] data);
  int base;
  base = addr & 32'hffff_fff8;
  for (int b = 0; b < 8; b++) begin
    if (strb[b]) begin
      model_mem[base + b] = data[b*8 +: 8];
    end
  end
endfunction

// both reads see the old words, then writes land port 0 first
function automatic void expect_response(
  input logic v0, input logic [31:0] a0, input logic [7:0] s0, input logic [63:0] d0,
  input logic v1, input logic [31:0] a1, input logic [7:0] s1, input logic [63:0] d1,
  output logic r0, output logic e0, output logic [63:0] q0,
  output logic r1, output logic e1, output logic [63:0] q1);
  r0 = v0;
  r1 = v1;
  e0 = v0 && !addr_in_range(a0);
  e1 = v1 && !addr_in_range(a1);
  q0 = (v0 && !e0) ? read_model_word(a0) : '0;
  q1 = (v1 && !e1) ? read_model_word(a1) : '0;
  if (v0 && !e0) begin
    write_model_word(a0, s0, d0);
  end
  if (v1 && !e1) begin
    write_model_word(a1, s1, d1); // port 1 wins a shared byte
  end
endfunction

`endif

// ==== verification/tim_tb.sv ====
`timescale 1ns/1ps
`include "tim_defs.svh"

module tim_tb;

  `include "tim_tb_model.svh"

  localparam int idle_cycles = 4;
  localparam int masked_count = 128;
  localparam int bad_count = 16;
  localparam int traffic_count = 200;
  localparam int total_requests = idle_cycles + 2 * word_count + masked_count
                                  + 3 * bad_count + traffic_count;
  localparam int timeout_ns = (total_requests + 50) * 100; // one request per 100 ns cycle

  logic clock = 1'b0;
  logic reset;
  logic port0_valid;
  logic [31:0] port0_addr;
  logic [7:0] port0_wstrb;
  logic [63:0] port0_wdata;
  logic port0_ready;
  logic [63:0] port0_rdata;
  logic port0_error;
  logic port1_valid;
  logic [31:0] port1_addr;
  logic [7:0] port1_wstrb;
  logic [63:0] port1_wdata;
  logic port1_ready;
  logic [63:0] port1_rdata;
  logic port1_error;

  logic exp_ready0 = 1'b0;
  logic exp_error0 = 1'b0;
  logic [63:0] exp_rdata0 = '0;
  logic exp_ready1 = 1'b0;
  logic exp_error1 = 1'b0;
  logic [63:0] exp_rdata1 = '0;
  string test_name = "";
  string exp_test = "";
  int test_errors = 0;
  int total_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_requests = 0;

  always #50 clock = ~clock;

  tim UUT (
    .clock(clock),
    .reset(reset),
    .port0_valid(port0_valid),
    .port0_addr(port0_addr),
    .port0_wstrb(port0_wstrb),
    .port0_wdata(port0_wdata),
    .port0_ready(port0_ready),
    .port0_rdata(port0_rdata),
    .port0_error(port0_error),
    .port1_valid(port1_valid),
    .port1_addr(port1_addr),
    .port1_wstrb(port1_wstrb),
    .port1_wdata(port1_wdata),
    .port1_ready(port1_ready),
    .port1_rdata(port1_rdata),
    .port1_error(port1_error)
  );

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s %s expected %h actual %h", exp_test, what, expected, actual);
    test_errors++;
    total_errors++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~ compare
  // outputs settle by the falling edge
  // inputs seen here are taken at the next rise
  always @(negedge clock) begin
    assert (port0_ready === exp_ready0)
      else report_mismatch("port0 ready", exp_ready0, port0_ready);
    assert (port0_error === exp_error0)
      else report_mismatch("port0 error", exp_error0, port0_error);
    if (exp_ready0 && !$isunknown(exp_rdata0)) begin
      assert (port0_rdata === exp_rdata0)
        else report_mismatch("port0 rdata", exp_rdata0, port0_rdata);
    end
    assert (port1_ready === exp_ready1)
      else report_mismatch("port1 ready", exp_ready1, port1_ready);
    assert (port1_error === exp_error1)
      else report_mismatch("port1 error", exp_error1, port1_error);
    if (exp_ready1 && !$isunknown(exp_rdata1)) begin
      assert (port1_rdata === exp_rdata1)
        else report_mismatch("port1 rdata", exp_rdata1, port1_rdata);
    end
    exp_test = test_name;
    if (reset) begin
      expect_response(port0_valid, port0_addr, port0_wstrb, port0_wdata,
                      port1_valid, port1_addr, port1_wstrb, port1_wdata,
                      exp_ready0, exp_error0, exp_rdata0, exp_ready1, exp_error1, exp_rdata1);
    end else begin
      exp_ready0 = 1'b0; // response registers held clear
      exp_error0 = 1'b0;
      exp_ready1 = 1'b0;
      exp_error1 = 1'b0;
    end
  end

  task automatic drive_request(
    input logic v0, input logic [31:0] a0, input logic [7:0] s0, input logic [63:0] d0,
    input logic v1, input logic [31:0] a1, input logic [7:0] s1, input logic [63:0] d1);
    @(posedge clock);
    port0_valid <= v0;
    port0_addr <= a0;
    port0_wstrb <= s0;
    port0_wdata <= d0;
    port1_valid <= v1;
    port1_addr <= a1;
    port1_wstrb <= s1;
    port1_wdata <= d1;
    test_requests += v0 + v1;
  endtask

  task automatic finish_test();
    drive_request(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
    wait (!exp_ready0 && !exp_ready1); // last responses checked
    if (test_errors == 0) begin
      $display("test %s: passed, %0d requests", test_name, test_requests);
    end else begin
      $display("test %s: failed, %0d errors", test_name, test_errors);
      tests_failed++;
    end
    tests_run++;
    test_errors = 0;
    test_requests = 0;
  endtask

  function automatic logic [31:0] bad_address();
    logic [31:0] a;
    a = random_bits(32);
    if (a < mem_bytes) begin
      a = a | mem_bytes; // low bits still alias a real word
    end
    return a;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~ stimulus
  initial begin
    logic [31:0] a0;
    logic [31:0] a1;
    logic [7:0] s0;
    logic [7:0] s1;
    logic [31:0] alias_q[$];
    reset <= 1'b0;
    port0_valid <= 1'b0;
    port0_addr <= '0;
    port0_wstrb <= '0;
    port0_wdata <= '0;
    port1_valid <= 1'b0;
    port1_addr <= '0;
    port1_wstrb <= '0;
    port1_wdata <= '0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;

    test_name = "reset state";
    repeat (idle_cycles) drive_request(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
    finish_test();

    test_name = "full write read";
    for (int w = 0; w < word_count; w++) begin
      drive_request(1'b1, w * 8, 8'hff, random_bits(64), 1'b0, '0, '0, '0);
    end
    for (int w = 0; w < word_count; w++) begin
      drive_request(1'b0, '0, '0, '0, 1'b1, w * 8 + random_bits(3), 8'h00, random_bits(64));
    end
    finish_test();

    test_name = "byte masked write";
    for (int i = 0; i < masked_count; i++) begin
      a0 = random_bits(8); // small pool so words are hit again
      s0 = random_bits(8);
      if (random_bits(1)) begin
        drive_request(1'b1, a0, s0, random_bits(64), 1'b0, '0, '0, '0);
      end else begin
        drive_request(1'b0, '0, '0, '0, 1'b1, a0, s0, random_bits(64));
      end
    end
    finish_test();

    test_name = "out of range";
    for (int i = 0; i < bad_count; i++) begin
      a0 = bad_address();
      a1 = bad_address();
      alias_q.push_back(a0 % mem_bytes);
      alias_q.push_back(a1 % mem_bytes);
      drive_request(1'b1, a0, random_bits(8), random_bits(64),
                    1'b1, a1, random_bits(8), random_bits(64));
    end
    while (alias_q.size() >= 2) begin
      a0 = alias_q.pop_front();
      a1 = alias_q.pop_front();
      drive_request(1'b1, a0, 8'h00, '0, 1'b1, a1, 8'h00, '0);
    end
    finish_test();

    test_name = "dual port traffic";
    for (int i = 0; i < traffic_count; i++) begin
      a0 = random_bits(32) % mem_bytes;
      a1 = (random_bits(2) == 0) ? a0 : random_bits(32) % mem_bytes; // same word collision
      s0 = random_bits(8);
      s1 = random_bits(8);
      if (random_bits(3) == 0) begin
        s0 = 8'h00;
      end
      if (random_bits(4) == 0) begin
        a1 = bad_address();
      end
      drive_request(1'b1, a0, s0, random_bits(64), 1'b1, a1, s1, random_bits(64));
    end
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~ watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: run did not finish within %0d ns", timeout_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
+incdir+verification
hw/tim_pkg.sv
hw/tim_decode.sv
hw/tim_bank.sv
hw/tim_response.sv
hw/tim.sv
verification/tim_tb.sv
